//--- compile.f
rv_mem_pkg.sv
load_ext.sv
lsu.sv
data_ram.sv
wb_stage.sv
mem_subsys_top.sv
tb_clkgen.sv
tb_mem_subsys.sv

//--- data_ram.sv
// word-organized data RAM with read/write channel handshakes and a fixed response latency
module data_ram #(
    parameter int ADDR_W      = 10,
    parameter int RAM_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_W-1:0]     araddr,
    input  logic                  arvalid,
    input  logic                  rready,
    output logic [31:0]           rdata,
    output logic                  rvalid,
    input  logic [ADDR_W-1:0]     awaddr,
    input  logic                  awvalid,
    input  logic [31:0]           wdata,
    input  rv_mem_pkg::mem_size_e wsize,
    input  logic                  wvalid,
    input  logic                  bready,
    output logic                  bvalid,
    output logic                  bresp
);
    import rv_mem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;
    localparam int CNT_W = $clog2(RAM_LATENCY + 1);

    logic [31:0]       mem [DEPTH];
    logic              busy;
    logic              req_wr;
    logic [CNT_W-1:0]  cnt;
    logic [ADDR_W-1:0] req_addr;
    logic [31:0]       req_wdata;
    mem_size_e         req_size;
    logic [3:0]        byte_en;
    logic              wr_take;
    logic              rd_take;
    logic              fire;

    assign wr_take = !busy && awvalid && wvalid;
    assign rd_take = !busy && arvalid && !wr_take;
    assign fire    = busy && (cnt == CNT_W'(1));   // last latency cycle

    // stores write the low bytes only
    always_comb begin
        case (req_size)
            SZ_B:    byte_en = 4'b0001;
            SZ_H:    byte_en = 4'b0011;
            SZ_W:    byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            req_wr <= 1'b0;
            cnt    <= '0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            bresp  <= 1'b0;
        end else if (wr_take || rd_take) begin
            busy   <= 1'b1;
            req_wr <= wr_take;
            cnt    <= CNT_W'(RAM_LATENCY);
        end else if (busy && (cnt != '0)) begin
            cnt <= cnt - CNT_W'(1);
            if (fire) begin
                rvalid <= !req_wr;
                bvalid <= req_wr;
                bresp  <= req_wr;
            end
        end else if ((rvalid && rready) || (bvalid && bready)) begin
            busy   <= 1'b0;   // stay busy through the response cycle
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            bresp  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            req_addr  <= awaddr;
            req_wdata <= wdata;
            req_size  <= wsize;
        end else if (rd_take) begin
            req_addr <= araddr;
        end
        if (fire && !req_wr) begin
            rdata <= mem[req_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (fire && req_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[req_addr][8*b +: 8] <= req_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- load_ext.sv
// load data widening; turns a raw RAM word into the register value for the given access size
module load_ext (
    input  logic [31:0]           raw,
    input  rv_mem_pkg::mem_size_e size,
    output logic [31:0]           data
);
    import rv_mem_pkg::*;

    always_comb begin
        case (size)
            SZ_B: begin
                data = {{24{raw[7]}}, raw[7:0]};
            end
            SZ_H: begin
                data = {{16{raw[15]}}, raw[15:0]};
            end
            SZ_W: begin
                data = raw;
            end
            SZ_BU: begin
                data = {24'd0, raw[7:0]};
            end
            SZ_HU: begin
                data = {16'd0, raw[15:0]};
            end
            default: begin
                data = '0;   // not a load code
            end
        endcase
    end

endmodule

//--- lsu.sv
// memory stage; registers the execute bundle, runs the RAM handshakes and feeds writeback
module lsu #(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_mem_pkg::ex_mem_t   in_bundle,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [ADDR_W-1:0]     araddr,
    output logic                  arvalid,
    output logic                  rready,
    input  logic [31:0]           rdata,
    input  logic                  rvalid,
    output logic [ADDR_W-1:0]     awaddr,
    output logic                  awvalid,
    output logic [31:0]           wdata,
    output rv_mem_pkg::mem_size_e wsize,
    output logic                  wvalid,
    output logic                  bready,
    input  logic                  bvalid,
    input  logic                  bresp,
    input  logic [31:0]           ext_data,
    output logic [31:0]           ext_raw,
    output rv_mem_pkg::mem_size_e ext_size,
    output rv_mem_pkg::mem_wb_t   out_bundle,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import rv_mem_pkg::*;

    lsu_state_e  state;
    lsu_state_e  state_nxt;
    lsu_state_e  take_state;
    ex_mem_t     req;
    logic [31:0] load_data;
    logic        take;
    logic        rd_done;
    logic        wr_done;

    assign take    = in_valid && in_ready;
    assign rd_done = rvalid && rready;
    assign wr_done = bvalid && bready && bresp;   // retry on error response

    // a held result may leave in the same cycle a new bundle arrives
    assign in_ready = (state == LSU_IDLE) || ((state == LSU_HOLD) && out_ready);

    always_comb begin
        if (in_bundle.mem_ren) begin
            take_state = LSU_RD_WAIT;
        end else if (in_bundle.mem_wen) begin
            take_state = LSU_WR_WAIT;
        end else begin
            take_state = LSU_HOLD;   // alu result, no memory access
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LSU_IDLE: begin
                if (take) begin
                    state_nxt = take_state;
                end
            end
            LSU_RD_WAIT: begin
                if (rd_done) begin
                    state_nxt = LSU_HOLD;
                end
            end
            LSU_WR_WAIT: begin
                if (wr_done) begin
                    state_nxt = LSU_HOLD;
                end
            end
            LSU_HOLD: begin
                if (take) begin
                    state_nxt = take_state;
                end else if (out_ready) begin
                    state_nxt = LSU_IDLE;
                end
            end
            default: begin
                state_nxt = LSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req <= in_bundle;
        end
        if (rd_done) begin
            load_data <= ext_data;   // already widened
        end
    end

    // read channel
    assign araddr  = req.ex_result[ADDR_W+1:2];
    assign arvalid = (state == LSU_RD_WAIT);
    assign rready  = (state == LSU_RD_WAIT);

    // write channel, strobes held until the response
    assign awaddr  = req.ex_result[ADDR_W+1:2];
    assign awvalid = (state == LSU_WR_WAIT);
    assign wvalid  = (state == LSU_WR_WAIT);
    assign bready  = (state == LSU_WR_WAIT);
    assign wdata   = req.rs2_value;
    assign wsize   = req.funct3;

    assign ext_raw  = rdata;
    assign ext_size = req.funct3;

    assign out_valid = (state == LSU_HOLD);

    always_comb begin
        out_bundle.pc        = req.pc;
        out_bundle.inst      = req.inst;
        out_bundle.ex_result = req.ex_result;
        out_bundle.mem_rdata = req.mem_ren ? load_data : 32'd0;
        out_bundle.csrs      = req.csrs;
        out_bundle.rd        = req.rd;
        out_bundle.r_wen     = req.r_wen;
        out_bundle.csr_wen   = req.csr_wen;
        out_bundle.mem_ren   = req.mem_ren;
        out_bundle.jump_flag = req.jump_flag;
    end

endmodule

//--- mem_subsys_top.sv
// top of the memory subsystem; wires lsu, load widening, data RAM and writeback together
module mem_subsys_top #(
    parameter int ADDR_W      = 10,
    parameter int RAM_LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::ex_mem_t in_bundle,
    input  logic                in_valid,
    output logic                in_ready,
    output rv_mem_pkg::commit_t commit,
    output logic                commit_valid,
    input  logic                commit_ready
);
    import rv_mem_pkg::*;

    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              rready;
    logic [31:0]       rdata;
    logic              rvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic [31:0]       wdata;
    mem_size_e         wsize;
    logic              wvalid;
    logic              bready;
    logic              bvalid;
    logic              bresp;
    logic [31:0]       ext_raw;
    logic [31:0]       ext_data;
    mem_size_e         ext_size;
    mem_wb_t           wb_bundle;
    logic              wb_valid;
    logic              wb_ready;

    lsu #(
        .ADDR_W (ADDR_W)
    ) lsu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_bundle  (in_bundle),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wsize      (wsize),
        .wvalid     (wvalid),
        .bready     (bready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .ext_data   (ext_data),
        .ext_raw    (ext_raw),
        .ext_size   (ext_size),
        .out_bundle (wb_bundle),
        .out_valid  (wb_valid),
        .out_ready  (wb_ready)
    );

    load_ext load_ext_inst (
        .raw  (ext_raw),
        .size (ext_size),
        .data (ext_data)
    );

    data_ram #(
        .ADDR_W      (ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) data_ram_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .wdata   (wdata),
        .wsize   (wsize),
        .wvalid  (wvalid),
        .bready  (bready),
        .bvalid  (bvalid),
        .bresp   (bresp)
    );

    wb_stage wb_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_bundle    (wb_bundle),
        .in_valid     (wb_valid),
        .in_ready     (wb_ready),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready)
    );

endmodule

//--- rv_mem_pkg.sv
// shared types for the memory stage, imported by every module of the memory subsystem
package rv_mem_pkg;

    // funct3 codes of loads and stores
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_RD_WAIT,
        LSU_WR_WAIT,
        LSU_HOLD
    } lsu_state_e;

    // execute to memory
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] ex_result;   // address for loads and stores
        logic [31:0] csrs;
        logic [31:0] rs2_value;   // store data
        logic [4:0]  rd;
        mem_size_e   funct3;
        logic        mem_ren;
        logic        mem_wen;
        logic        r_wen;
        logic [3:0]  csr_wen;
        logic        jump_flag;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] ex_result;
        logic [31:0] mem_rdata;   // zero unless a load
        logic [31:0] csrs;
        logic [4:0]  rd;
        logic        r_wen;
        logic [3:0]  csr_wen;
        logic        mem_ren;
        logic        jump_flag;
    } mem_wb_t;

    // retired instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        r_wen;
        logic [3:0]  csr_wen;
        logic [31:0] csrs;
        logic        jump_flag;
    } commit_t;

endpackage

//--- tb_clkgen.sv
// clock and reset source for the memory subsystem testbench, instantiated once by its top
module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released on a falling edge
    end

endmodule

//--- tb_mem_subsys.sv
// directed tests of the memory subsystem against a word-array reference model; simulation top
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_mem_pkg::*;

    localparam int ADDR_W         = 10;
    localparam int RAM_LATENCY    = 2;
    localparam int PERIOD_NS      = 10;
    localparam int N_ALU          = 20;
    localparam int N_WORD         = 16;
    localparam int N_WIDEN        = 8;
    localparam int N_MERGE        = 8;
    localparam int N_STALL        = 60;
    localparam int N_X0           = 10;
    localparam int TOTAL_BUNDLES  = N_ALU + 2 * N_WORD + 6 * N_WIDEN + 5 * N_MERGE + N_STALL + N_X0;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_BUNDLES + 8;

    logic        clk;
    logic        rst_n;
    ex_mem_t     in_bundle;
    logic        in_valid;
    logic        in_ready;
    commit_t     commit;
    logic        commit_valid;
    logic        commit_ready;

    logic [31:0] ref_mem [1 << ADDR_W];
    commit_t     exp_q [$];
    commit_t     exp_c;
    int          errors;
    bit          stall_on;
    string       cur_test;
    mem_size_e   load_sizes [5] = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU};
    mem_size_e   store_sizes [3] = '{SZ_B, SZ_H, SZ_W};

    tb_clkgen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (8)
    ) tb_clkgen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top #(
        .ADDR_W      (ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) mem_subsys_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_bundle    (in_bundle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready)
    );

    function automatic logic [31:0] widen(input logic [31:0] word, input mem_size_e size);
        case (size)
            SZ_B:    return 32'($signed(word[7:0]));
            SZ_H:    return 32'($signed(word[15:0]));
            SZ_W:    return word;
            SZ_BU:   return 32'(word[7:0]);
            SZ_HU:   return 32'(word[15:0]);
            default: return 32'd0;
        endcase
    endfunction

    // store keeps the bytes above the access size
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input mem_size_e size);
        case (size)
            SZ_B:    return {old[31:8], data[7:0]};
            SZ_H:    return {old[31:16], data[15:0]};
            SZ_W:    return data;
            default: return old;
        endcase
    endfunction

    function automatic ex_mem_t rand_bundle();
        ex_mem_t b;
        b.pc        = $urandom();
        b.inst      = $urandom();
        b.ex_result = $urandom();
        b.csrs      = $urandom();
        b.rs2_value = $urandom();
        b.rd        = 5'($urandom());
        b.funct3    = SZ_W;
        b.mem_ren   = 1'b0;
        b.mem_wen   = 1'b0;
        b.r_wen     = 1'($urandom());
        b.csr_wen   = 4'($urandom());
        b.jump_flag = 1'($urandom());
        return b;
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return (32'(idx % (1 << ADDR_W)) << 2) | 32'($urandom_range(3, 0));   // low bits ignored
    endfunction

    task automatic issue_bundle(input ex_mem_t b);
        commit_t           c;
        logic [ADDR_W-1:0] idx;
        idx         = b.ex_result[ADDR_W+1:2];
        c.pc        = b.pc;
        c.inst      = b.inst;
        c.rd        = b.rd;
        c.r_wen     = b.r_wen;
        c.csr_wen   = b.csr_wen;
        c.csrs      = b.csrs;
        c.jump_flag = b.jump_flag;
        c.wdata     = b.mem_ren ? widen(ref_mem[idx], b.funct3) : b.ex_result;
        if (b.mem_wen && !b.mem_ren) begin
            ref_mem[idx] = merge(ref_mem[idx], b.rs2_value, b.funct3);
        end
        exp_q.push_back(c);
        @(negedge clk);
        in_bundle = b;
        in_valid  = 1'b1;
        do begin
            @(posedge clk);
        end while (!in_ready);
    endtask

    task automatic do_alu(input logic [4:0] rd);
        ex_mem_t b;
        b    = rand_bundle();
        b.rd = rd;
        issue_bundle(b);
    endtask

    task automatic do_store(input int idx, input logic [31:0] data, input mem_size_e size);
        ex_mem_t b;
        b           = rand_bundle();
        b.mem_wen   = 1'b1;
        b.r_wen     = 1'b0;
        b.ex_result = word_addr(idx);
        b.rs2_value = data;
        b.funct3    = size;
        issue_bundle(b);
    endtask

    task automatic do_load(input int idx, input mem_size_e size, input logic [4:0] rd);
        ex_mem_t b;
        b           = rand_bundle();
        b.mem_ren   = 1'b1;
        b.r_wen     = 1'b1;
        b.rd        = rd;
        b.ex_result = word_addr(idx);
        b.funct3    = size;
        issue_bundle(b);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // room for a stray commit to show up
    endtask

    task automatic test_alu_pass();
        cur_test = "alu_pass";
        for (int i = 0; i < N_ALU; i++) begin
            do_alu(5'($urandom()));
        end
        drain();
    endtask

    task automatic test_word_store_load();
        int idx [N_WORD];
        cur_test = "word_store_load";
        for (int i = 0; i < N_WORD; i++) begin
            idx[i] = $urandom_range((1 << ADDR_W) - 1, 0);
            do_store(idx[i], $urandom(), SZ_W);
        end
        for (int i = 0; i < N_WORD; i++) begin
            do_load(idx[i], SZ_W, 5'($urandom_range(31, 1)));
        end
        drain();
    endtask

    task automatic test_widening();
        logic [31:0] data;
        cur_test = "byte_half_widening";
        for (int i = 0; i < N_WIDEN; i++) begin
            // half of the values have the sign bits set
            data = (i % 4 < 2) ? ($urandom() | 32'h0000_8080) : ($urandom() & 32'hffff_7f7f);
            do_store(32 + i, data, (i % 2 == 1) ? SZ_H : SZ_B);
            for (int k = 0; k < 5; k++) begin
                do_load(32 + i, load_sizes[k], 5'($urandom_range(31, 1)));
            end
        end
        drain();
    endtask

    task automatic test_partial_stores();
        cur_test = "partial_stores";
        for (int i = 0; i < N_MERGE; i++) begin
            do_store(64 + i, $urandom(), SZ_W);
            do_store(64 + i, $urandom(), SZ_B);
            do_load(64 + i, SZ_W, 5'($urandom_range(31, 1)));
            do_store(64 + i, $urandom(), SZ_H);
            do_load(64 + i, SZ_W, 5'($urandom_range(31, 1)));
        end
        drain();
    endtask

    task automatic test_backpressure();
        int idx;
        cur_test = "backpressure";
        stall_on = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            idx = $urandom_range(15, 0);   // small window so loads see earlier stores
            case ($urandom_range(2, 0))
                0: do_alu(5'($urandom()));
                1: do_store(idx, $urandom(), store_sizes[$urandom_range(2, 0)]);
                default: do_load(idx, load_sizes[$urandom_range(4, 0)], 5'($urandom()));
            endcase
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end
        end
        drain();
        stall_on = 1'b0;
    endtask

    task automatic test_x0();
        cur_test = "register_x0";
        for (int i = 0; i < N_X0; i++) begin
            if (i % 2 == 1) begin
                do_alu(5'd0);
            end else begin
                do_load(i, SZ_W, 5'd0);
            end
        end
        drain();
    endtask

    always @(negedge clk) begin
        if (stall_on) begin
            commit_ready = ($urandom_range(1, 0) == 1);
        end else begin
            commit_ready = 1'b1;
        end
    end

    // commit monitor, checks every accepted commit in order
    always @(posedge clk) begin
        if (rst_n === 1'b1 && commit_valid === 1'b1 && commit_ready === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("ERROR: %s: commit seen with nothing outstanding, pc %h", cur_test,
                         commit.pc);
            end
            if (exp_q.size() != 0) begin
                exp_c = exp_q.pop_front();
                assert (commit === exp_c) else begin
                    errors++;
                    $display("MISMATCH %s: expected %h actual %h", cur_test, exp_c, commit);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD_NS);
        $display("ERROR: watchdog expired in %s, the DUT stopped accepting or committing",
                 cur_test);
        $display("errors: %0d", errors + 1);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        in_bundle    = '0;
        in_valid     = 1'b0;
        commit_ready = 1'b1;
        stall_on     = 1'b0;
        errors       = 0;
        cur_test     = "reset";
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            ref_mem[i] = 32'd0;   // RAM clears on reset
        end
        void'($urandom(32'he3db));
        wait (rst_n === 1'b1);
        assert (in_ready === 1'b1 && commit_valid === 1'b0) else begin
            errors++;
            $display("ERROR: reset: in_ready should be high and commit_valid low after reset");
        end
        test_alu_pass();
        test_word_store_load();
        test_widening();
        test_partial_stores();
        test_backpressure();
        test_x0();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- wb_stage.sv
// writeback stage; picks the result, updates the register file and holds the commit port
module wb_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_mem_pkg::mem_wb_t in_bundle,
    input  logic                in_valid,
    output logic                in_ready,
    output rv_mem_pkg::commit_t commit,
    output logic                commit_valid,
    input  logic                commit_ready
);

    logic [31:0] regs [1:31];   // x0 hardwired to zero
    logic        take;
    logic        retire;

    assign in_ready = !commit_valid || commit_ready;
    assign take     = in_valid && in_ready;
    assign retire   = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (take) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            commit.pc        <= in_bundle.pc;
            commit.inst      <= in_bundle.inst;
            commit.rd        <= in_bundle.rd;
            commit.wdata     <= in_bundle.mem_ren ? in_bundle.mem_rdata : in_bundle.ex_result;
            commit.r_wen     <= in_bundle.r_wen;
            commit.csr_wen   <= in_bundle.csr_wen;
            commit.csrs      <= in_bundle.csrs;
            commit.jump_flag <= in_bundle.jump_flag;
        end
    end

    // write on retirement only
    always_ff @(posedge clk) begin
        if (retire && commit.r_wen && (commit.rd != 5'd0)) begin
            regs[commit.rd] <= commit.wdata;
        end
    end

endmodule
